/* common/pac_pkg.sv */
package pac_pkg;

    // playfield in tiles
    localparam int grid_w = 40;
    localparam int grid_h = 30;
    localparam int x_w = 6;
    localparam int y_w = 5;

    localparam int num_ghosts = 4;

    // score counts eaten tiles, at most grid_w * grid_h
    localparam int score_w = 12;
    localparam int bcd_digits = 4;
    localparam int bcd_w = 16;

    typedef enum logic [2:0] {
        dir_none,
        dir_right,
        dir_left,
        dir_up,
        dir_down
    } dir_t;

    typedef struct packed {
        logic [x_w-1:0] x;
        logic [y_w-1:0] y;
    } pos_t;

    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } buttons_t;

    typedef struct packed {
        pos_t                  pacman;
        pos_t [num_ghosts-1:0] ghost;
    } sprites_t;

    localparam pos_t pacman_start = '{x: 6'd39, y: 5'd2};

    // index 3 down to 0: clyde, inky, pinky, blinky
    localparam pos_t [num_ghosts-1:0] ghost_start = {
        pos_t'{x: 6'd17, y: 5'd21},
        pos_t'{x: 6'd10, y: 5'd2},
        pos_t'{x: 6'd17, y: 5'd14},
        pos_t'{x: 6'd20, y: 5'd25}
    };

endpackage

/* motion/ghost_chase.sv */
`timescale 1ns/1ps

module ghost_chase (
    input  pac_pkg::pos_t ghost,
    input  pac_pkg::pos_t target,
    output pac_pkg::pos_t step
);

    logic [pac_pkg::x_w-1:0] dx;
    logic [pac_pkg::x_w-1:0] dy_ext;
    logic [pac_pkg::y_w-1:0] dy;

    // absolute distances on each axis
    assign dx = (target.x > ghost.x) ? target.x - ghost.x : ghost.x - target.x;
    assign dy = (target.y > ghost.y) ? target.y - ghost.y : ghost.y - target.y;
    assign dy_ext = {{(pac_pkg::x_w - pac_pkg::y_w){1'b0}}, dy};

    // larger distance first, x wins a tie
    always_comb begin
        step = ghost;
        if (dx != '0 && dx >= dy_ext) begin
            if (target.x > ghost.x)
                step.x = ghost.x + 1'b1;
            else
                step.x = ghost.x - 1'b1;
        end else if (dy != '0) begin
            if (target.y > ghost.y)
                step.y = ghost.y + 1'b1;
            else
                step.y = ghost.y - 1'b1;
        end
    end

endmodule

/* motion/sprite_motion.sv */
`timescale 1ns/1ps

module sprite_motion (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  pac_pkg::dir_t     pac_dir,
    input  logic              caught,
    output pac_pkg::sprites_t cur,
    output pac_pkg::sprites_t next
);

    localparam pac_pkg::sprites_t start_tiles = '{
        pacman: pac_pkg::pacman_start,
        ghost:  pac_pkg::ghost_start
    };

    pac_pkg::pos_t                           pac_step;
    pac_pkg::pos_t [pac_pkg::num_ghosts-1:0] ghost_step;

    // one tile in pac_dir, stopped at the grid edge
    always_comb begin
        pac_step = cur.pacman;
        case (pac_dir)
            pac_pkg::dir_right: begin
                if (int'(cur.pacman.x) < pac_pkg::grid_w - 1)
                    pac_step.x = cur.pacman.x + 1'b1;
            end
            pac_pkg::dir_left: begin
                if (cur.pacman.x != '0)
                    pac_step.x = cur.pacman.x - 1'b1;
            end
            pac_pkg::dir_up: begin
                if (cur.pacman.y != '0)
                    pac_step.y = cur.pacman.y - 1'b1;
            end
            pac_pkg::dir_down: begin
                if (int'(cur.pacman.y) < pac_pkg::grid_h - 1)
                    pac_step.y = cur.pacman.y + 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ghosts chase the pre-tick pacman tile
    for (genvar g = 0; g < pac_pkg::num_ghosts; g++) begin : gen_ghost
        ghost_chase ghost_chase_inst (
            .ghost  (cur.ghost[g]),
            .target (cur.pacman),
            .step   (ghost_step[g])
        );
    end

    assign next = '{pacman: pac_step, ghost: ghost_step};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur <= start_tiles;
        end else if (tick) begin
            if (caught)
                cur <= start_tiles;
            else
                cur <= next;
        end
    end

endmodule

/* scoring/food_score.sv */
`timescale 1ns/1ps

module food_score (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tick,
    input  pac_pkg::sprites_t           cur,
    input  pac_pkg::sprites_t           next,
    output logic                        caught,
    output logic                        dead,
    output logic [pac_pkg::score_w-1:0] score
);

    localparam int tiles = pac_pkg::grid_w * pac_pkg::grid_h;
    localparam int food_w = $clog2(tiles);

    // one bit per tile, set means food still there
    logic [tiles-1:0]  food;
    logic [food_w-1:0] food_idx;

    // same next tile, or pacman and a ghost swapping tiles in one tick
    always_comb begin
        caught = 1'b0;
        for (int g = 0; g < pac_pkg::num_ghosts; g++) begin
            if (next.pacman == next.ghost[g])
                caught = 1'b1;
            if (next.pacman == cur.ghost[g] && next.ghost[g] == cur.pacman)
                caught = 1'b1;
        end
    end

    // row major tile index
    assign food_idx = food_w'(next.pacman.y) * food_w'(pac_pkg::grid_w)
                    + food_w'(next.pacman.x);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            food  <= '1;
            score <= '0;
            dead  <= 1'b0;
        end else begin
            dead <= tick && caught;
            if (tick) begin
                if (caught) begin
                    food  <= '1;
                    score <= '0;
                end else if (food[food_idx]) begin
                    food[food_idx] <= 1'b0;
                    score          <= score + 1'b1;
                end
            end
        end
    end

endmodule

/* scoring/score_bcd.sv */
`timescale 1ns/1ps

module score_bcd (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [pac_pkg::score_w-1:0] score,
    output logic [pac_pkg::bcd_w-1:0]   score_bcd
);

    logic [pac_pkg::bcd_w-1:0] bcd;

    // double dabble, add 3 to any digit of 5 or more before each shift
    always_comb begin
        bcd = '0;
        for (int i = pac_pkg::score_w - 1; i >= 0; i--) begin
            for (int d = 0; d < pac_pkg::bcd_digits; d++) begin
                if (bcd[4*d +: 4] >= 4'd5)
                    bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
            end
            bcd = {bcd[pac_pkg::bcd_w-2:0], score[i]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            score_bcd <= '0;
        else
            score_bcd <= bcd;
    end

endmodule

/* rtl/button_decode.sv */
`timescale 1ns/1ps

module button_decode (
    input  logic              clk,
    input  logic              rst,
    input  pac_pkg::buttons_t btn,
    output pac_pkg::dir_t     pac_dir
);

    // priority right, left, up, down
    // no button pressed keeps the last direction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pac_dir <= pac_pkg::dir_none;
        end else if (btn.right) begin
            pac_dir <= pac_pkg::dir_right;
        end else if (btn.left) begin
            pac_dir <= pac_pkg::dir_left;
        end else if (btn.up) begin
            pac_dir <= pac_pkg::dir_up;
        end else if (btn.down) begin
            pac_dir <= pac_pkg::dir_down;
        end
    end

endmodule

/* rtl/pac_game_top.sv */
`timescale 1ns/1ps

module pac_game_top (
    input  logic                           clk,
    input  logic                           rst,
    input  pac_pkg::buttons_t              btn,
    input  logic                           tick,
    output pac_pkg::sprites_t              sprites,
    output pac_pkg::dir_t                  pac_dir,
    output logic                           dead,
    output logic [pac_pkg::bcd_w-1:0]      score_bcd
);

    pac_pkg::sprites_t             cur;
    pac_pkg::sprites_t             next;
    logic                          caught;
    logic [pac_pkg::score_w-1:0]   score;

    button_decode button_decode_inst (
        .clk     (clk),
        .rst     (rst),
        .btn     (btn),
        .pac_dir (pac_dir)
    );

    sprite_motion sprite_motion_inst (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .pac_dir (pac_dir),
        .caught  (caught),
        .cur     (cur),
        .next    (next)
    );

    food_score food_score_inst (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .cur    (cur),
        .next   (next),
        .caught (caught),
        .dead   (dead),
        .score  (score)
    );

    score_bcd score_bcd_inst (
        .clk       (clk),
        .rst       (rst),
        .score     (score),
        .score_bcd (score_bcd)
    );

    // registered positions go straight out
    assign sprites = cur;

endmodule

/* verification/pac_game_checker.sv */
`timescale 1ns/1ps

module pac_game_checker (
    input logic              clk,
    input logic              rst,
    input logic              tick,
    input logic              dead,
    input pac_pkg::sprites_t sprites
);

    logic in_grid;

    always_comb begin
        in_grid = int'(sprites.pacman.x) < pac_pkg::grid_w
               && int'(sprites.pacman.y) < pac_pkg::grid_h;
        for (int g = 0; g < pac_pkg::num_ghosts; g++) begin
            if (int'(sprites.ghost[g].x) >= pac_pkg::grid_w
                || int'(sprites.ghost[g].y) >= pac_pkg::grid_h)
                in_grid = 1'b0;
        end
    end

    // catch pulse lasts one cycle
    dead_single: assert property (@(posedge clk) disable iff (rst) dead |=> !dead)
        else $error("dead was high on two consecutive cycles");

    sprites_hold: assert property (@(posedge clk) disable iff (rst) !tick |=> $stable(sprites))
        else $error("sprites changed without a tick");

    grid_bounds: assert property (@(posedge clk) disable iff (rst) in_grid)
        else $error("a sprite left the grid");

endmodule

/* verification/pac_game_tb.sv */
`timescale 1ns/1ps

module pac_game_tb;

    localparam int max_tests = 32;
    localparam int margin_cycles = 100;

    logic                      clk;
    logic                      rst;
    pac_pkg::buttons_t         btn;
    logic                      tick;
    pac_pkg::sprites_t         sprites;
    pac_pkg::dir_t             pac_dir;
    logic                      dead;
    logic [pac_pkg::bcd_w-1:0] score_bcd;

    // one entry per trace line
    string       t_name [max_tests];
    logic [3:0]  t_btn [max_tests];
    int          t_ticks [max_tests];
    int          t_gap [max_tests];
    int          t_px [max_tests];
    int          t_py [max_tests];
    int          t_gx [max_tests];
    int          t_gy [max_tests];
    int          t_dead [max_tests];
    logic [15:0] t_bcd [max_tests];

    int num_tests;
    int dead_count;
    int error_count;
    int failed_tests;
    int cycle_count = 0;
    int cycle_limit = margin_cycles;

    // direction the pad should be holding
    pac_pkg::dir_t held_dir;

    pac_game_top pac_game_top_inst (
        .clk       (clk),
        .rst       (rst),
        .btn       (btn),
        .tick      (tick),
        .sprites   (sprites),
        .pac_dir   (pac_dir),
        .dead      (dead),
        .score_bcd (score_bcd)
    );

    bind pac_game_top pac_game_checker pac_game_checker_inst (
        .clk     (clk),
        .rst     (rst),
        .tick    (tick),
        .dead    (dead),
        .sprites (sprites)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
            $display("Regression failed");
            $finish;
        end
    end

    // one clock while counting catch pulses
    task automatic wait_cycle();
        @(negedge clk);
        if (dead)
            dead_count++;
    endtask

    // bits are right, left, up, down from msb down
    function automatic pac_pkg::dir_t expected_dir(input logic [3:0] bits,
                                                   input pac_pkg::dir_t held);
        pac_pkg::dir_t dir;
        casez (bits)
            4'b1???: dir = pac_pkg::dir_right;
            4'b01??: dir = pac_pkg::dir_left;
            4'b001?: dir = pac_pkg::dir_up;
            4'b0001: dir = pac_pkg::dir_down;
            default: dir = held;
        endcase
        return dir;
    endfunction

    task automatic load_trace();
        int          fd;
        int          code;
        string       word;
        string       rest;
        logic [3:0]  bits;
        int          ticks;
        int          gap;
        int          px;
        int          py;
        int          gx;
        int          gy;
        int          deads;
        logic [15:0] bcd;
        num_tests = 0;
        fd = $fopen("verification/pac_game_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            error_count++;
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                code = $fscanf(fd, "%s", word);
                if (code == 1 && word.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (code == 1) begin
                    code = $fscanf(fd, "%b %d %d %d %d %d %d %d %h",
                                   bits, ticks, gap, px, py, gx, gy, deads, bcd);
                    if (code == 9) begin
                        t_name[num_tests] = word;
                        t_btn[num_tests] = bits;
                        t_ticks[num_tests] = ticks;
                        t_gap[num_tests] = gap;
                        t_px[num_tests] = px;
                        t_py[num_tests] = py;
                        t_gx[num_tests] = gx;
                        t_gy[num_tests] = gy;
                        t_dead[num_tests] = deads;
                        t_bcd[num_tests] = bcd;
                        num_tests++;
                    end else begin
                        $display("trace line for %s is malformed", word);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int i);
        int errors;
        errors = 0;
        dead_count = 0;
        held_dir = expected_dir(t_btn[i], held_dir);
        // buttons latch one cycle before the first tick
        btn = pac_pkg::buttons_t'(t_btn[i]);
        wait_cycle();
        for (int n = 0; n < t_ticks[i]; n++) begin
            tick = 1'b1;
            wait_cycle();
            tick = 1'b0;
            if (n < t_ticks[i] - 1)
                repeat (t_gap[i]) wait_cycle();
        end
        // bcd trails the binary score by one more cycle
        repeat (2) wait_cycle();
        if (pac_dir != held_dir) begin
            $display("Fail %s pac_dir expected %s actual %s",
                     t_name[i], held_dir.name(), pac_dir.name());
            errors++;
        end
        if (int'(sprites.pacman.x) != t_px[i]) begin
            $display("Fail %s pacman x expected %0d actual %0d",
                     t_name[i], t_px[i], sprites.pacman.x);
            errors++;
        end
        if (int'(sprites.pacman.y) != t_py[i]) begin
            $display("Fail %s pacman y expected %0d actual %0d",
                     t_name[i], t_py[i], sprites.pacman.y);
            errors++;
        end
        if (int'(sprites.ghost[0].x) != t_gx[i]) begin
            $display("Fail %s blinky x expected %0d actual %0d",
                     t_name[i], t_gx[i], sprites.ghost[0].x);
            errors++;
        end
        if (int'(sprites.ghost[0].y) != t_gy[i]) begin
            $display("Fail %s blinky y expected %0d actual %0d",
                     t_name[i], t_gy[i], sprites.ghost[0].y);
            errors++;
        end
        if (dead_count != t_dead[i]) begin
            $display("Fail %s dead pulses expected %0d actual %0d",
                     t_name[i], t_dead[i], dead_count);
            errors++;
        end
        if (score_bcd != t_bcd[i]) begin
            $display("Fail %s score_bcd expected %04h actual %04h",
                     t_name[i], t_bcd[i], score_bcd);
            errors++;
        end
        if (errors == 0) begin
            $display("%s: ok", t_name[i]);
        end else begin
            $display("%s: %0d wrong values", t_name[i], errors);
            failed_tests++;
        end
        error_count += errors;
    endtask

    initial begin
        rst = 1'b1;
        btn = '0;
        tick = 1'b0;
        held_dir = pac_pkg::dir_none;
        error_count = 0;
        failed_tests = 0;
        dead_count = 0;
        load_trace();
        cycle_limit = margin_cycles;
        for (int i = 0; i < num_tests; i++)
            cycle_limit += t_ticks[i] * (t_gap[i] + 1);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < num_tests; i++)
            run_test(i);
        $display("tests %0d, passed %0d, failed %0d",
                 num_tests, num_tests - failed_tests, failed_tests);
        if (error_count == 0 && num_tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verification/pac_game_trace.txt */
# name buttons(right left up down) ticks gap pac_x pac_y ghost0_x ghost0_y dead score_bcd
# runs in order without reset, values hold two cycles after the last tick of the line
reset      0000  0 0 39 2 20 25 0 0000
left_gap   0100  4 3 35 2 20 21 0 0004
left_catch 0100 11 1 39 2 20 25 1 0000
left_b2b   0100  4 0 35 2 20 21 0 0004
right_back 1000  4 2 39 2 22 19 0 0005
right_edge 1000  1 1 39 2 23 19 0 0005
up         0010  1 1 39 1 23 18 0 0006
release    0000  1 1 39 0 23 17 0 0007
down_eat   0001  7 1 39 7 29 16 0 0012

/* verilog.f */
common/pac_pkg.sv
motion/ghost_chase.sv
motion/sprite_motion.sv
scoring/food_score.sv
scoring/score_bcd.sv
rtl/button_decode.sv
rtl/pac_game_top.sv
verification/pac_game_checker.sv
verification/pac_game_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = pac_game_tb
FILELIST  = verilog.f
TRACE     = verification/pac_game_trace.txt

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST) $(TRACE)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
